//--- sources.f
hdl/calc_data_pkg.sv
hdl/calc_ctrl_pkg.sv
hdl/key_fifo.sv
hdl/digit_counter.sv
hdl/addsub_unit.sv
hdl/shift_multiplier.sv
hdl/calc_ctrl.sv
hdl/calc_top.sv
verif/calc_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = calc_tb
FILELIST  = sources.f
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- verif/calc_tb.sv
`timescale 1ns/10ps

module calc_tb import calc_data_pkg::*, calc_ctrl_pkg::*;;

    logic              clk;
    logic              nRST;
    logic              key_valid;
    key_t              key;
    logic              key_credit;
    logic              complete;
    logic [DATA_W-1:0] result;

    string             row_name[$];        // Stimulus table, one entry per expression
    string             row_keys[$];        // Digits, + - * operators, = equal, C clear
    logic [15:0]       row_expect[$];
    int                row_gap[$];         // Idle cycles between keys, 0 for a burst
    logic [15:0]       results[$];         // Values seen with complete
    int                sent;
    int                returned;
    bit                table_ready;

    calc_top calc_top_i (
        .clk        (clk),
        .nRST       (nRST),
        .key_valid  (key_valid),
        .key        (key),
        .key_credit (key_credit),
        .complete   (complete),
        .result     (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (nRST && key_credit) begin
            returned <= returned + 1;       // One credit back per consumed key
        end
        if (nRST && complete) begin
            results.push_back(result);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Modulo 2^16, also for negative differences
    function automatic logic [15:0] wrap16(input int value);
        return 16'(((value % 65536) + 65536) % 65536);
    endfunction

    function automatic key_t to_key(input byte c);
        key_t k;
        k = '0;
        case (c)
            "+": begin
                k.kind = KEY_OP;
                k.op   = OP_ADD;
            end
            "-": begin
                k.kind = KEY_OP;
                k.op   = OP_SUB;
            end
            "*": begin
                k.kind = KEY_OP;
                k.op   = OP_MUL;
            end
            "=": k.kind = KEY_EQUAL;
            "C": k.kind = KEY_CLEAR;
            default: begin
                k.kind  = KEY_DIGIT;
                k.digit = 4'(c - 8'd48);
            end
        endcase
        return k;
    endfunction

    task automatic add_row(input string name, input string keys, input logic [15:0] exp,
                           input int gap);
        row_name.push_back(name);
        row_keys.push_back(keys);
        row_expect.push_back(exp);
        row_gap.push_back(gap);
    endtask

    // Host side of the credit protocol
    task automatic send_keys(input string seq, input int gap);
        int pos;
        int outstanding;
        pos = 0;
        while (pos < seq.len()) begin
            @(posedge clk);
            outstanding = sent - returned;
            check_value("credit without key", 32'd1, 32'(outstanding >= 0));
            if (outstanding < KEY_CREDITS) begin
                key_valid <= 1'b1;
                key       <= to_key(seq[pos]);
                sent++;
                pos++;
                if (gap > 0) begin
                    @(posedge clk);
                    key_valid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end else begin
                key_valid <= 1'b0;          // Out of credits, hold off
            end
        end
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    initial begin
        int          a;
        int          b;
        logic [15:0] got;
        clk         = 1'b0;
        nRST        = 1'b0;
        key_valid   = 1'b0;
        key         = '0;
        sent        = 0;
        returned    = 0;
        table_ready = 0;
        void'($urandom(32'h4521_77f7));

        add_row("add multi digit", "123+456=", wrap16(123 + 456), 20);
        add_row("sub multi digit", "1000-1=", wrap16(1000 - 1), 20);
        add_row("sub wrap", "3-5=", wrap16(3 - 5), 20);
        add_row("mul low bits", "9999*9999=", wrap16(9999 * 9999), 20);
        add_row("fifth digit", "12345+1=", wrap16(1234 + 1), 20);
        add_row("second operator", "12+3-4=", wrap16(12 + 34), 20);
        add_row("clear", "12+3C4+5=", wrap16(4 + 5), 20);
        add_row("single operand", "42=", wrap16(42), 20);
        add_row("burst add", "123+456=", wrap16(123 + 456), 0);
        add_row("burst mul", "9999*9999=", wrap16(9999 * 9999), 0);
        add_row("burst clear", "77*8C6-9=", wrap16(6 - 9), 0);
        a = int'($urandom % 10000);
        b = int'($urandom % 10000);
        add_row("random add", $sformatf("%0d+%0d=", a, b), wrap16(a + b), 0);
        a = int'($urandom % 10000);
        b = int'($urandom % 10000);
        add_row("random sub", $sformatf("%0d-%0d=", a, b), wrap16(a - b), 20);
        a = int'($urandom % 10000);
        b = int'($urandom % 10000);
        add_row("random mul", $sformatf("%0d*%0d=", a, b), wrap16(a * b), 0);
        table_ready = 1;

        repeat (16) @(posedge clk);
        nRST <= 1'b1;
        repeat (2) @(posedge clk);

        foreach (row_name[i]) begin
            send_keys(row_keys[i], row_gap[i]);
            while (results.size() == 0) begin
                @(posedge clk);             // Result of this expression
            end
            got = results.pop_front();
            check_value(row_name[i], 32'(row_expect[i]), 32'(got));
        end

        repeat (50) @(posedge clk);
        check_value("stray complete count", 32'd0, 32'(results.size()));
        check_value("credits returned", 32'(sent), 32'(returned));
        $display("Done: no errors");
        $finish;
    end

    // Timeout scaled by the number of keys in the table
    initial begin
        int total;
        int limit;
        total = 0;
        wait (table_ready);
        foreach (row_keys[i]) begin
            total += row_keys[i].len();
        end
        limit = total * 40 + 300;
        repeat (limit) @(posedge clk);
        $display("calculator stopped answering within %0d cycles", limit);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

//--- hdl/calc_top.sv
`timescale 1ns/10ps

module calc_top import calc_data_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic              key_valid,
    input  key_t              key,
    output logic              key_credit,
    output logic              complete,
    output logic [DATA_W-1:0] result
);

    key_t              head;
    logic              not_empty;
    logic              pop;
    logic              count_digit;
    logic              clear_count;
    logic              at_limit;
    logic [DATA_W-1:0] unit_a;              // Shared operand bus to both units
    logic [DATA_W-1:0] unit_b;
    logic              sub;
    logic              add_start;
    logic              mul_start;
    logic [DATA_W-1:0] sum;
    logic [DATA_W-1:0] product;
    logic              add_finish;
    logic              mul_finish;

    key_fifo key_fifo_i (
        .clk       (clk),
        .nRST      (nRST),
        .key_valid (key_valid),
        .key       (key),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (key_credit)
    );

    digit_counter digit_counter_i (
        .clk         (clk),
        .nRST        (nRST),
        .count_digit (count_digit),
        .clear_count (clear_count),
        .at_limit    (at_limit)
    );

    calc_ctrl calc_ctrl_i (
        .clk         (clk),
        .nRST        (nRST),
        .head        (head),
        .not_empty   (not_empty),
        .at_limit    (at_limit),
        .add_finish  (add_finish),
        .mul_finish  (mul_finish),
        .sum         (sum),
        .product     (product),
        .pop         (pop),
        .count_digit (count_digit),
        .clear_count (clear_count),
        .unit_a      (unit_a),
        .unit_b      (unit_b),
        .sub         (sub),
        .add_start   (add_start),
        .mul_start   (mul_start),
        .complete    (complete),
        .result      (result)
    );

    addsub_unit addsub_unit_i (
        .clk    (clk),
        .nRST   (nRST),
        .a      (unit_a),
        .b      (unit_b),
        .sub    (sub),
        .start  (add_start),
        .sum    (sum),
        .finish (add_finish)
    );

    shift_multiplier shift_multiplier_i (
        .clk     (clk),
        .nRST    (nRST),
        .a       (unit_a),
        .b       (unit_b),
        .start   (mul_start),
        .product (product),
        .finish  (mul_finish)
    );

endmodule

//--- hdl/calc_ctrl.sv
`timescale 1ns/10ps

module calc_ctrl import calc_data_pkg::*, calc_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  key_t              head,
    input  logic              not_empty,
    input  logic              at_limit,
    input  logic              add_finish,
    input  logic              mul_finish,
    input  logic [DATA_W-1:0] sum,
    input  logic [DATA_W-1:0] product,
    output logic              pop,
    output logic              count_digit,
    output logic              clear_count,
    output logic [DATA_W-1:0] unit_a,
    output logic [DATA_W-1:0] unit_b,
    output logic              sub,
    output logic              add_start,
    output logic              mul_start,
    output logic              complete,
    output logic [DATA_W-1:0] result
);

    ctrl_state_t       state;
    opcode_t           opcode;              // Operator of the current expression
    logic [DATA_W-1:0] operand1;
    logic [DATA_W-1:0] operand2;
    logic [3:0]        new_digit;           // Digit waiting for the times ten
    logic [3:0]        digit_val;
    logic              in_get;

    assign in_get    = (state == GET_OP1) || (state == GET_OP2);
    assign pop       = in_get && not_empty; // Keys are only taken while waiting for input
    assign digit_val = (head.digit > 4'd9) ? 4'd9 : head.digit;

    assign count_digit = pop && (head.kind == KEY_DIGIT) && !at_limit;
    assign clear_count = (pop && (head.kind == KEY_CLEAR))
                       || (pop && (head.kind == KEY_OP) && (state == GET_OP1))
                       || (state == SHOW_RESULT);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= GET_OP1;
            opcode    <= OP_ADD;
            operand1  <= '0;
            operand2  <= '0;
            new_digit <= '0;
            unit_a    <= '0;
            unit_b    <= '0;
            sub       <= 1'b0;
            add_start <= 1'b0;
            mul_start <= 1'b0;
            complete  <= 1'b0;
            result    <= '0;
        end else begin
            add_start <= 1'b0;
            mul_start <= 1'b0;
            complete  <= 1'b0;
            case (state)
                GET_OP1, GET_OP2: begin
                    if (pop) begin
                        case (head.kind)
                            KEY_DIGIT: begin
                                if (!at_limit) begin    // Extra digits are dropped
                                    unit_a    <= (state == GET_OP1) ? operand1 : operand2;
                                    unit_b    <= DECIMAL_BASE;
                                    mul_start <= 1'b1;
                                    new_digit <= digit_val;
                                    state     <= (state == GET_OP1) ? ACC_OP1 : ACC_OP2;
                                end
                            end
                            KEY_OP: begin
                                if (state == GET_OP1) begin
                                    opcode <= head.op;
                                    state  <= GET_OP2;
                                end
                            end
                            KEY_EQUAL: begin
                                if (state == GET_OP1) begin
                                    result   <= operand1;   // Lone operand is the answer
                                    complete <= 1'b1;
                                    state    <= SHOW_RESULT;
                                end else begin
                                    unit_a <= operand1;
                                    unit_b <= operand2;
                                    if (opcode == OP_MUL) begin
                                        mul_start <= 1'b1;
                                        state     <= RUN_MUL;
                                    end else begin
                                        sub       <= (opcode == OP_SUB);
                                        add_start <= 1'b1;
                                        state     <= RUN_ADDSUB;
                                    end
                                end
                            end
                            default: begin          // Clear key
                                operand1 <= '0;
                                operand2 <= '0;
                                state    <= GET_OP1;
                            end
                        endcase
                    end
                end
                ACC_OP1: begin
                    if (mul_finish) begin
                        operand1 <= product + DATA_W'(new_digit);
                        state    <= GET_OP1;
                    end
                end
                ACC_OP2: begin
                    if (mul_finish) begin
                        operand2 <= product + DATA_W'(new_digit);
                        state    <= GET_OP2;
                    end
                end
                RUN_ADDSUB: begin
                    if (add_finish) begin
                        result   <= sum;
                        complete <= 1'b1;
                        state    <= SHOW_RESULT;
                    end
                end
                RUN_MUL: begin
                    if (mul_finish) begin
                        result   <= product;
                        complete <= 1'b1;
                        state    <= SHOW_RESULT;
                    end
                end
                SHOW_RESULT: begin
                    operand1 <= '0;                 // Next expression starts fresh
                    operand2 <= '0;
                    state    <= GET_OP1;
                end
                default: state <= GET_OP1;
            endcase
        end
    end

endmodule

//--- hdl/shift_multiplier.sv
`timescale 1ns/10ps

module shift_multiplier import calc_data_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic              start,
    output logic [DATA_W-1:0] product,
    output logic              finish
);

    logic [DATA_W-1:0]         mcand;       // Multiplicand
    logic [DATA_W-1:0]         mplier;      // Multiplier
    logic [DATA_W-1:0]         acc;         // Partial product, low bits only
    logic [$clog2(DATA_W)-1:0] idx;         // Current multiplier bit
    logic                      busy;

    assign product = acc;

    // Bit 0 is handled on the start edge, bits 1 to DATA_W-1 while busy
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= b[0] ? a : '0;
        end else if (busy && mplier[idx]) begin
            acc <= acc + (mcand << idx);    // Upper bits drop out
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            idx    <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                idx  <= 1;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (int'(idx) == DATA_W - 1) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;         // DATA_W cycles after start
                end
            end
        end
    end

endmodule

//--- hdl/addsub_unit.sv
`timescale 1ns/10ps

module addsub_unit import calc_data_pkg::*; (
    input  logic              clk,
    input  logic              nRST,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic              sub,
    input  logic              start,
    output logic [DATA_W-1:0] sum,
    output logic              finish
);

    // Result wraps modulo 2^DATA_W in both directions
    always_ff @(posedge clk) begin
        if (start) begin
            sum <= sub ? (a - b) : (a + b);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;                // Result is ready one cycle after start
        end
    end

endmodule

//--- hdl/digit_counter.sv
`timescale 1ns/10ps

module digit_counter import calc_ctrl_pkg::*; (
    input  logic clk,
    input  logic nRST,
    input  logic count_digit,
    input  logic clear_count,
    output logic at_limit
);

    logic [$clog2(MAX_DIGITS+1)-1:0] count;     // Digits in the current operand

    assign at_limit = (int'(count) == MAX_DIGITS);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear_count) begin
            count <= '0;                    // New operand starts from zero digits
        end else if (count_digit && !at_limit) begin
            count <= count + 1'b1;          // Saturates at the limit
        end
    end

endmodule

//--- hdl/key_fifo.sv
`timescale 1ns/10ps

module key_fifo import calc_data_pkg::*, calc_ctrl_pkg::*; (
    input  logic clk,
    input  logic nRST,
    input  logic key_valid,
    input  key_t key,
    input  logic pop,
    output key_t head,
    output logic not_empty,
    output logic credit
);

    key_t mem [KEY_CREDITS];                // Key storage

    logic [$clog2(KEY_CREDITS)-1:0]   wr_ptr;
    logic [$clog2(KEY_CREDITS)-1:0]   rd_ptr;
    logic [$clog2(KEY_CREDITS+1)-1:0] count;

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Host never sends without a credit, so no full check
    always_ff @(posedge clk) begin
        if (key_valid) begin
            mem[wr_ptr] <= key;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;                  // One credit back per consumed key
            if (key_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (key_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !key_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // Controller states
    typedef enum logic [2:0] {
        GET_OP1     = 3'd0,                 // Waiting for keys of the first operand
        ACC_OP1     = 3'd1,                 // Folding a digit into operand1
        GET_OP2     = 3'd2,
        ACC_OP2     = 3'd3,
        RUN_ADDSUB  = 3'd4,
        RUN_MUL     = 3'd5,
        SHOW_RESULT = 3'd6
    } ctrl_state_t;

    // Queue depth, also the host's credit count after reset
    localparam int KEY_CREDITS = 4;

    // Digits accepted per operand
    localparam int MAX_DIGITS = 4;

endpackage

//--- hdl/calc_data_pkg.sv
package calc_data_pkg;

    // Operand and result width
    localparam int DATA_W = 16;

    // Multiplier applied to an operand before each new digit
    localparam logic [15:0] DECIMAL_BASE = 16'd10;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_SUB = 2'b01,
        OP_MUL = 2'b10
    } opcode_t;

    typedef enum logic [1:0] {
        KEY_DIGIT = 2'b00,
        KEY_OP    = 2'b01,
        KEY_EQUAL = 2'b10,
        KEY_CLEAR = 2'b11
    } key_kind_t;

    // One key event from the host, 8 bits
    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;                  // Only for KEY_DIGIT, above 9 reads as 9
        opcode_t    op;                     // Only for KEY_OP
    } key_t;

endpackage
